// ==== Bender.yml ====
package:
  name: branch_predictor

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/bp_table_pkg.sv
      - common/bp_ctrl_pkg.sv
      - bht/bht_lookup.sv
      - bht/bht_table.sv
      - source/branch_resolve.sv
      - source/branch_predictor.sv
  - target: test
    include_dirs:
      - common
    files:
      - testbench/bp_properties.sv
      - testbench/tb_branch_predictor.sv

// ==== bht/bht_lookup.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_defs.svh"

module bht_lookup (
	input  bp_table_pkg::bht_entry_t [`BP_WAYS-1:0] entries,
	input  bp_table_pkg::bht_tag_t                  tag,
	output logic                                    hit,
	output bp_table_pkg::bht_entry_t                entry,
	output logic [`BP_WAY_W-1:0]                    way
);

	import bp_table_pkg::*;

	// one bit per way, set when valid and tag equal
	logic [`BP_WAYS-1:0] match;

	// selected line, zero on a miss
	bht_entry_t found;

	////////////////////////////////////////
	// tag compare
	////////////////////////////////////////

	always_comb begin
		for (int w = 0; w < `BP_WAYS; w++) begin
			match[w] = entries[w].valid && (entries[w].tag == tag);
		end
	end

	////////////////////////////////////////
	// way select
	////////////////////////////////////////

	// only a single matching way counts as a hit
	always_comb begin
		hit   = 1'b0;
		found = '0;
		way   = '0;
		if ($onehot(match)) begin
			hit = 1'b1;
			for (int w = 0; w < `BP_WAYS; w++) begin
				if (match[w]) begin
					found = entries[w];
					way   = w[`BP_WAY_W-1:0];
				end
			end
		end
	end

	assign entry = found;

endmodule

`default_nettype wire

// ==== bht/bht_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_defs.svh"

module bht_table (
	input  logic                      CLK,
	input  logic                      nrst,
	input  logic                      en,
	input  logic                      isr_en,
	input  logic [`BP_PC_W-1:0]       if_pc,
	input  logic [`BP_PC_W-1:0]       id_pc,
	input  bp_table_pkg::bht_target_t id_target,
	input  logic                      id_is_jump,
	input  logic                      id_is_btype,
	input  logic [`BP_PC_W-1:0]       exe_pc,
	input  logic                      exe_taken,
	input  logic                      exe_btype_any,
	output logic                      if_hit,
	output logic                      if_pred,
	output bp_table_pkg::bht_target_t if_pbt,
	output logic                      id_hit,
	output logic                      exe_hit,
	output bp_table_pkg::sat_cnt_t    exe_cnt,
	output bp_table_pkg::bht_target_t exe_pbt
);

	import bp_table_pkg::*;

	typedef bht_entry_t [`BP_WAYS-1:0] bht_set_t;

	// valid bits and fifo pointers are cleared by reset
	logic [`BP_WAYS-1:0]  valid_q [`BP_SETS];
	logic [`BP_WAY_W-1:0] fifo_q  [`BP_SETS];

	// line payload
	bht_tag_t    tag_q [`BP_SETS][`BP_WAYS];
	bht_target_t tgt_q [`BP_SETS][`BP_WAYS];
	sat_cnt_t    cnt_q [`BP_SETS][`BP_WAYS];

	logic [`BP_SET_W-1:0] if_set, id_set, exe_set;
	bht_tag_t             if_tag, id_tag, exe_tag;
	bht_set_t             if_lines, id_lines, exe_lines;
	bht_entry_t           if_entry, exe_entry;
	logic [`BP_WAY_W-1:0] exe_way;
	logic                 id_insert, exe_train;
	sat_cnt_t             cnt_next;

	// gather the four ways of one set
	function automatic bht_set_t read_set(input logic [`BP_SET_W-1:0] s);
		bht_set_t r;
		for (int w = 0; w < `BP_WAYS; w++) begin
			r[w].valid  = valid_q[s][w];
			r[w].tag    = tag_q[s][w];
			r[w].target = tgt_q[s][w];
			r[w].cnt    = cnt_q[s][w];
		end
		return r;
	endfunction

	////////////////////////////////////////
	// lookups
	////////////////////////////////////////

	assign if_set  = if_pc[`BP_SET_W-1:0];
	assign id_set  = id_pc[`BP_SET_W-1:0];
	assign exe_set = exe_pc[`BP_SET_W-1:0];
	assign if_tag  = {isr_en, if_pc[`BP_PC_W-1:`BP_SET_W]};
	assign id_tag  = {isr_en, id_pc[`BP_PC_W-1:`BP_SET_W]};
	assign exe_tag = {isr_en, exe_pc[`BP_PC_W-1:`BP_SET_W]};

	always_comb begin
		if_lines  = read_set(if_set);
		id_lines  = read_set(id_set);
		exe_lines = read_set(exe_set);
	end

	bht_lookup if_lookup (.entries(if_lines), .tag(if_tag), .hit(if_hit),
		.entry(if_entry), .way());
	bht_lookup id_lookup (.entries(id_lines), .tag(id_tag), .hit(id_hit),
		.entry(), .way());
	bht_lookup exe_lookup (.entries(exe_lines), .tag(exe_tag), .hit(exe_hit),
		.entry(exe_entry), .way(exe_way));

	// miss gives a zero line, so prediction reads not taken
	assign if_pred = if_entry.cnt[1];
	assign if_pbt  = if_entry.target;
	assign exe_cnt = exe_entry.cnt;
	assign exe_pbt = exe_entry.target;

	////////////////////////////////////////
	// updates
	////////////////////////////////////////

	// new branch or jump not yet stored
	assign id_insert = (id_is_btype || id_is_jump) && !id_hit;
	// stored branch resolving in exe
	assign exe_train = exe_btype_any && exe_hit;

	// saturate at 3 and 0
	always_comb begin
		if (exe_taken)
			cnt_next = (exe_cnt == 2'd3) ? exe_cnt : exe_cnt + 2'd1;
		else
			cnt_next = (exe_cnt == 2'd0) ? exe_cnt : exe_cnt - 2'd1;
	end

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			for (int s = 0; s < `BP_SETS; s++) begin
				valid_q[s] <= '0;
				fifo_q[s]  <= '0;
			end
		end else if (en && id_insert) begin
			valid_q[id_set][fifo_q[id_set]] <= 1'b1;
			// wraps from 3 back to 0
			fifo_q[id_set] <= fifo_q[id_set] + 1'b1;
		end
	end

	// insert wins, training in the same cycle is lost
	always_ff @(posedge CLK) begin
		if (en) begin
			if (id_insert) begin
				tag_q[id_set][fifo_q[id_set]] <= id_tag;
				tgt_q[id_set][fifo_q[id_set]] <= id_target;
				cnt_q[id_set][fifo_q[id_set]] <= id_is_jump ? `BP_CNT_JUMP : `BP_CNT_BRANCH;
			end else if (exe_train) begin
				cnt_q[exe_set][exe_way] <= cnt_next;
			end
		end
	end

endmodule

`default_nettype wire

// ==== common/bp_ctrl_pkg.sv ====
`default_nettype none

package bp_ctrl_pkg;

	// one-hot branch kind seen in exe
	// all zero when exe holds no branch
	typedef logic [5:0] btype_t;

	// bit positions inside btype_t
	localparam int BT_BEQ  = 5;
	localparam int BT_BNE  = 4;
	localparam int BT_BLT  = 3;
	localparam int BT_BGE  = 2;
	localparam int BT_BLTU = 1;
	localparam int BT_BGEU = 0;

	// pc correction requested by exe
	typedef enum logic [1:0] {
		NO_CORR  = 2'd0,
		CORR_CNI = 2'd2,
		CORR_PBT = 2'd3
	} correction_e;

endpackage

`default_nettype wire

// ==== common/bp_defs.svh ====
`ifndef BP_DEFS_SVH
`define BP_DEFS_SVH

// program counter width, word addressed
`define BP_PC_W 10

// table geometry
`define BP_SETS 16
`define BP_WAYS 4

// index widths for set and way
`define BP_SET_W 4
`define BP_WAY_W 2

// counter value for a freshly placed branch, weakly not taken
`define BP_CNT_BRANCH 2'd1

// counter value for a freshly placed jump, strongly taken
`define BP_CNT_JUMP 2'd3

`endif

// ==== common/bp_table_pkg.sv ====
`default_nettype none

`include "bp_defs.svh"

package bp_table_pkg;

	// isr flag on top, then the pc bits above the set index
	typedef logic [`BP_PC_W-`BP_SET_W:0] bht_tag_t;

	// stored branch target
	typedef logic [`BP_PC_W-1:0] bht_target_t;

	// 2-bit saturating counter
	// upper bit is the taken prediction
	typedef logic [1:0] sat_cnt_t;

	// one table line, 20 bits
	typedef struct packed {
		logic        valid;
		bht_tag_t    tag;
		bht_target_t target;
		sat_cnt_t    cnt;
	} bht_entry_t;

endpackage

`default_nettype wire

// ==== source/branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_defs.svh"

module branch_predictor (
	input  logic                      CLK,
	input  logic                      nrst,
	input  logic                      en,
	input  logic                      isr_en,
	input  logic [`BP_PC_W-1:0]       if_pc,
	input  logic [`BP_PC_W-1:0]       id_pc,
	input  bp_table_pkg::bht_target_t id_target,
	input  logic                      id_is_jump,
	input  logic                      id_is_btype,
	input  logic [`BP_PC_W-1:0]       exe_pc,
	input  logic                      exe_z,
	input  logic                      exe_less,
	input  bp_ctrl_pkg::btype_t       exe_btype,
	output logic                      if_prediction,
	output bp_table_pkg::bht_target_t if_pbt,
	output bp_table_pkg::bht_target_t exe_pbt,
	output logic [`BP_PC_W-1:0]       exe_cni,
	output bp_ctrl_pkg::correction_e  exe_correction,
	output logic [`BP_PC_W-1:0]       next_pc,
	output logic                      branch_flush,
	output logic                      id_jump_in_bht
);

	// table to resolver
	logic                   exe_hit;
	logic                   id_hit;
	bp_table_pkg::sat_cnt_t exe_cnt;

	// resolver back to table
	logic exe_taken;
	logic exe_btype_any;

	bht_table table_i (
		.CLK(CLK), .nrst(nrst), .en(en), .isr_en(isr_en),
		.if_pc(if_pc), .id_pc(id_pc), .id_target(id_target),
		.id_is_jump(id_is_jump), .id_is_btype(id_is_btype),
		.exe_pc(exe_pc), .exe_taken(exe_taken), .exe_btype_any(exe_btype_any),
		.if_hit(), .if_pred(if_prediction), .if_pbt(if_pbt), .id_hit(id_hit),
		.exe_hit(exe_hit), .exe_cnt(exe_cnt), .exe_pbt(exe_pbt)
	);

	branch_resolve resolve_i (
		.CLK(CLK), .nrst(nrst), .en(en), .exe_btype(exe_btype),
		.exe_z(exe_z), .exe_less(exe_less), .exe_hit(exe_hit),
		.exe_cnt(exe_cnt), .exe_pc(exe_pc), .exe_pbt(exe_pbt),
		.if_pc(if_pc), .if_pred(if_prediction), .if_pbt(if_pbt),
		.id_is_jump(id_is_jump), .id_hit(id_hit),
		.exe_taken(exe_taken), .exe_btype_any(exe_btype_any),
		.exe_correction(exe_correction), .exe_cni(exe_cni),
		.next_pc(next_pc), .branch_flush(branch_flush),
		.id_jump_in_bht(id_jump_in_bht)
	);

endmodule

`default_nettype wire

// ==== source/branch_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_defs.svh"

module branch_resolve (
	input  logic                     CLK,
	input  logic                     nrst,
	input  logic                     en,
	input  bp_ctrl_pkg::btype_t      exe_btype,
	input  logic                     exe_z,
	input  logic                     exe_less,
	input  logic                     exe_hit,
	input  logic [1:0]               exe_cnt,
	input  logic [`BP_PC_W-1:0]      exe_pc,
	input  logic [`BP_PC_W-1:0]      exe_pbt,
	input  logic [`BP_PC_W-1:0]      if_pc,
	input  logic                     if_pred,
	input  logic [`BP_PC_W-1:0]      if_pbt,
	input  logic                     id_is_jump,
	input  logic                     id_hit,
	output logic                     exe_taken,
	output logic                     exe_btype_any,
	output bp_ctrl_pkg::correction_e exe_correction,
	output logic [`BP_PC_W-1:0]      exe_cni,
	output logic [`BP_PC_W-1:0]      next_pc,
	output logic                     branch_flush,
	output logic                     id_jump_in_bht
);

	import bp_ctrl_pkg::*;

	logic pred_taken;
	logic mispredict;
	logic flush_q, flush_d;

	////////////////////////////////////////
	// outcome and correction
	////////////////////////////////////////

	// signed and unsigned compares share the alu less flag
	assign exe_taken = (exe_btype[BT_BEQ]  &&  exe_z)    ||
	                   (exe_btype[BT_BNE]  && !exe_z)    ||
	                   (exe_btype[BT_BLT]  &&  exe_less) ||
	                   (exe_btype[BT_BGE]  && !exe_less) ||
	                   (exe_btype[BT_BLTU] &&  exe_less) ||
	                   (exe_btype[BT_BGEU] && !exe_less);

	assign exe_btype_any = |exe_btype;

	// a missing entry reads as counter 0
	assign pred_taken = exe_hit && exe_cnt[1];
	assign mispredict = exe_btype_any && (pred_taken != exe_taken);

	always_comb begin
		if (!mispredict)
			exe_correction = NO_CORR;
		else if (exe_taken)
			exe_correction = CORR_PBT;
		else
			exe_correction = CORR_CNI;
	end

	// fall-through address of the exe branch
	assign exe_cni = exe_pc + 1'b1;

	// exe correction first, then the if prediction
	always_comb begin
		case (exe_correction)
			CORR_PBT: next_pc = exe_pbt;
			CORR_CNI: next_pc = exe_cni;
			default:  next_pc = if_pred ? if_pbt : if_pc + 1'b1;
		endcase
	end

	////////////////////////////////////////
	// flush
	////////////////////////////////////////

	// pending flush blocks any new one
	always_comb begin
		if (flush_q) begin
			branch_flush = 1'b1;
			flush_d      = 1'b0;
		end else if (mispredict) begin
			branch_flush = 1'b1;
			flush_d      = 1'b1;
		end else begin
			branch_flush = 1'b0;
			// new jump flushes one cycle later
			flush_d      = id_is_jump && !id_hit;
		end
	end

	always_ff @(posedge CLK) begin
		if (!nrst)
			flush_q <= 1'b0;
		else if (en)
			flush_q <= flush_d;
	end

	assign id_jump_in_bht = id_is_jump && id_hit;

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+common
common/bp_table_pkg.sv
common/bp_ctrl_pkg.sv
bht/bht_lookup.sv
bht/bht_table.sv
source/branch_resolve.sv
source/branch_predictor.sv
testbench/bp_properties.sv
testbench/tb_branch_predictor.sv

// ==== testbench/bp_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module bp_properties (
	input logic                     CLK,
	input logic                     nrst,
	input bp_ctrl_pkg::btype_t      exe_btype,
	input logic                     exe_z,
	input logic                     exe_less,
	input logic                     exe_hit,
	input logic [1:0]               exe_cnt,
	input bp_ctrl_pkg::correction_e exe_correction,
	input logic                     branch_flush,
	input logic                     id_jump_in_bht,
	input logic                     id_is_jump
);

	import bp_ctrl_pkg::*;

	logic taken;
	logic mispredict;

	// set once any property fails
	logic failed = 1'b0;

	// outcome decoded again from the one-hot kind and the alu flags
	assign taken = (exe_btype[5] && exe_z) || (exe_btype[4] && !exe_z) ||
	               ((exe_btype[3] || exe_btype[1]) && exe_less) ||
	               ((exe_btype[2] || exe_btype[0]) && !exe_less);
	// a missing entry predicts not taken
	assign mispredict = (|exe_btype) && ((exe_hit && exe_cnt[1]) != taken);

	////////////////////////////////////////
	// properties
	////////////////////////////////////////

	a_corr_code: assert property (@(posedge CLK) disable iff (!nrst)
		exe_correction != 2'd1)
		else begin
			$error("exe_correction holds the unused code 1");
			failed = 1'b1;
		end

	a_flush_after_reset: assert property (@(posedge CLK) $rose(nrst) |-> !branch_flush)
		else begin
			$error("branch_flush is high right after reset");
			failed = 1'b1;
		end

	a_mispredict_flush: assert property (@(posedge CLK) disable iff (!nrst)
		mispredict |-> branch_flush)
		else begin
			$error("mispredicted branch without branch_flush");
			failed = 1'b1;
		end

	a_jump_in_bht: assert property (@(posedge CLK) disable iff (!nrst)
		id_jump_in_bht |-> id_is_jump)
		else begin
			$error("id_jump_in_bht high without a jump in ID");
			failed = 1'b1;
		end

endmodule

// attach to the predictor top where exe_hit and exe_cnt are internal wires
bind branch_predictor bp_properties props_i (.*);

`default_nettype wire

// ==== testbench/tb_branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "bp_defs.svh"

module tb_branch_predictor;

	import bp_table_pkg::*;
	import bp_ctrl_pkg::*;

	localparam int N_RAND     = 3000;
	localparam int N_DIRECTED = 60;
	// reset, directed and random cycles at 100 ns each plus a margin
	localparam int TIMEOUT_NS = (8 + N_DIRECTED + N_RAND) * 100 + 5000;

	logic        CLK, nrst, en, isr_en;
	logic [9:0]  if_pc, id_pc, exe_pc;
	bht_target_t id_target, if_pbt, exe_pbt;
	logic        id_is_jump, id_is_btype, exe_z, exe_less;
	btype_t      exe_btype;
	logic        if_prediction, branch_flush, id_jump_in_bht;
	logic [9:0]  exe_cni, next_pc;
	correction_e exe_correction;

	// reference model of the table, fifo pointers and flush bit
	logic        m_valid [`BP_SETS][`BP_WAYS];
	logic [6:0]  m_tag   [`BP_SETS][`BP_WAYS];
	logic [9:0]  m_tgt   [`BP_SETS][`BP_WAYS];
	logic [1:0]  m_cnt   [`BP_SETS][`BP_WAYS];
	logic [1:0]  m_fifo  [`BP_SETS];
	logic        m_flush;

	logic [31:0] lfsr = 32'h34df7241;
	string       test_name;

	branch_predictor uut (.*);

	always #50 CLK = ~CLK;

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Test FAILED");
		$fatal(1, "timeout, the test did not reach its end");
	end

	// a failed bound property ends the run
	initial begin
		wait (uut.props_i.failed === 1'b1);
		$display("Test FAILED");
		$fatal(1, "a bound property on the predictor failed");
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// galois lfsr stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r    = {r[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return r;
	endfunction

	// 8 addresses with 4 tags in set 2 and 4 in set 11
	function automatic logic [9:0] pool_pc(input logic [2:0] i);
		return {4'b0100, i[1:0], i[2] ? 4'hb : 4'h2};
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act) begin
			$display("** Error %s %s: expected %0h, actual %0h", test_name, name, exp, act);
			$display("Test FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// way of a single tag match in the model or -1 on a miss
	function automatic int find_way(input logic [9:0] pc);
		int found;
		int n;
		found = -1;
		n     = 0;
		for (int w = 0; w < `BP_WAYS; w++) begin
			if (m_valid[pc[3:0]][w] && m_tag[pc[3:0]][w] == {isr_en, pc[9:4]}) begin
				found = w;
				n++;
			end
		end
		return (n == 1) ? found : -1;
	endfunction

	// compare all outputs with the model and then advance the model
	task automatic evaluate;
		int         iw, dw, xw;
		logic [3:0] is, ds, xs;
		logic       pred, taken, mis;
		logic [1:0] xcnt, corr, w;
		logic [9:0] ipbt, xpbt, cni, npc;
		iw   = find_way(if_pc);
		dw   = find_way(id_pc);
		xw   = find_way(exe_pc);
		is   = if_pc[3:0];
		ds   = id_pc[3:0];
		xs   = exe_pc[3:0];
		pred = (iw >= 0) ? m_cnt[is][iw][1] : 1'b0;
		ipbt = (iw >= 0) ? m_tgt[is][iw] : 10'd0;
		xcnt = (xw >= 0) ? m_cnt[xs][xw] : 2'd0;
		xpbt = (xw >= 0) ? m_tgt[xs][xw] : 10'd0;
		// beq, bne, blt, bge, bltu, bgeu from top bit down
		taken = (exe_btype[5] && exe_z) || (exe_btype[4] && !exe_z) ||
		        ((exe_btype[3] || exe_btype[1]) && exe_less) ||
		        ((exe_btype[2] || exe_btype[0]) && !exe_less);
		mis  = (exe_btype != 6'd0) && (xcnt[1] != taken);
		corr = !mis ? 2'd0 : (taken ? 2'd3 : 2'd2);
		cni  = exe_pc + 10'd1;
		npc  = (corr == 2'd3) ? xpbt : (corr == 2'd2) ? cni : pred ? ipbt : if_pc + 10'd1;
		check("if_prediction", pred, if_prediction);
		check("if_pbt", ipbt, if_pbt);
		check("exe_pbt", xpbt, exe_pbt);
		check("exe_cni", cni, exe_cni);
		check("exe_correction", corr, exe_correction);
		check("next_pc", npc, next_pc);
		check("branch_flush", m_flush || mis, branch_flush);
		check("id_jump_in_bht", id_is_jump && dw >= 0, id_jump_in_bht);
		if (en) begin
			if ((id_is_btype || id_is_jump) && dw < 0) begin
				w              = m_fifo[ds];
				m_valid[ds][w] = 1'b1;
				m_tag[ds][w]   = {isr_en, id_pc[9:4]};
				m_tgt[ds][w]   = id_target;
				m_cnt[ds][w]   = id_is_jump ? 2'd3 : 2'd1;
				m_fifo[ds]     = w + 2'd1;
			end else if (exe_btype != 6'd0 && xw >= 0) begin
				if (taken && xcnt != 2'd3)
					m_cnt[xs][xw] = xcnt + 2'd1;
				else if (!taken && xcnt != 2'd0)
					m_cnt[xs][xw] = xcnt - 2'd1;
			end
			m_flush = m_flush ? 1'b0 : (mis || (id_is_jump && dw < 0));
		end
	endtask

	// drive 5 ns after the rising edge and check at the falling edge
	task automatic cycle(input logic e, input logic isr, input logic [9:0] ipc,
		input logic [9:0] dpc, input logic [9:0] dtgt, input logic dj, input logic db,
		input logic [9:0] xpc, input logic z, input logic l, input btype_t bt);
		@(posedge CLK);
		#5;
		en          = e;
		isr_en      = isr;
		if_pc       = ipc;
		id_pc       = dpc;
		id_target   = dtgt;
		id_is_jump  = dj;
		id_is_btype = db;
		exe_pc      = xpc;
		exe_z       = z;
		exe_less    = l;
		exe_btype   = bt;
		@(negedge CLK);
		evaluate();
	endtask

	task automatic random_cycle;
		logic       e, isr, z, l;
		logic [1:0] kind;
		logic [2:0] bsel;
		logic [9:0] ipc, dpc, xpc, tgt;
		// en low about one cycle in four
		e    = (rand_bits(2) != 0);
		isr  = (rand_bits(3) == 0);
		ipc  = pool_pc(3'(rand_bits(3)));
		dpc  = pool_pc(3'(rand_bits(3)));
		xpc  = pool_pc(3'(rand_bits(3)));
		tgt  = 10'(rand_bits(10));
		kind = 2'(rand_bits(2));
		z    = rand_bits(1) != 0;
		l    = rand_bits(1) != 0;
		bsel = 3'(rand_bits(3));
		cycle(e, isr, ipc, dpc, tgt, kind == 2'd2, kind == 2'd1, xpc, z, l,
			(bsel < 3'd6) ? (6'b1 << bsel) : 6'b0);
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial begin
		CLK         = 1'b0;
		nrst        = 1'b0;
		en          = 1'b0;
		isr_en      = 1'b0;
		if_pc       = '0;
		id_pc       = '0;
		id_target   = '0;
		id_is_jump  = 1'b0;
		id_is_btype = 1'b0;
		exe_pc      = '0;
		exe_z       = 1'b0;
		exe_less    = 1'b0;
		exe_btype   = '0;
		m_flush     = 1'b0;
		for (int s = 0; s < `BP_SETS; s++) begin
			m_fifo[s] = 2'd0;
			for (int w = 0; w < `BP_WAYS; w++) begin
				m_valid[s][w] = 1'b0;
				m_tag[s][w]   = '0;
				m_tgt[s][w]   = '0;
				m_cnt[s][w]   = '0;
			end
		end
		repeat (8) @(posedge CLK);
		#5;
		nrst = 1'b1;

		// empty table and then one branch insert
		test_name = "reset_first_insert";
		cycle(1, 0, 10'h013, 10'h000, 10'h000, 0, 0, 10'h000, 0, 0, 6'd0);
		check("miss next_pc", 10'h014, next_pc);
		cycle(1, 0, 10'h013, 10'h013, 10'h155, 0, 1, 10'h000, 0, 0, 6'd0);
		cycle(1, 0, 10'h013, 10'h000, 10'h000, 0, 0, 10'h000, 0, 0, 6'd0);
		check("insert target", 10'h155, if_pbt);
		check("insert prediction", 0, if_prediction);

		// five tags into set 5 evict the first one
		test_name = "fifo_replace";
		for (int k = 1; k <= 5; k++)
			cycle(1, 0, 10'h000, {6'(k), 4'h5}, 10'h200 + 10'(k), 0, 1, 10'h000, 0, 0, 6'd0);
		for (int k = 1; k <= 5; k++) begin
			cycle(1, 0, {6'(k), 4'h5}, 10'h000, 10'h000, 0, 0, 10'h000, 0, 0, 6'd0);
			check("lookup after wrap", (k == 1) ? 10'h000 : 10'h200 + 10'(k), if_pbt);
		end

		// beq taken up to saturation and then bne not taken down to 0
		test_name = "counter_training";
		repeat (4) cycle(1, 0, 10'h013, 10'h000, 10'h000, 0, 0, 10'h013, 1, 0, 6'b100000);
		cycle(1, 0, 10'h013, 10'h000, 10'h000, 0, 0, 10'h000, 0, 0, 6'd0);
		check("trained taken", 1, if_prediction);
		repeat (5) cycle(1, 0, 10'h013, 10'h000, 10'h000, 0, 0, 10'h013, 1, 0, 6'b010000);
		cycle(1, 0, 10'h013, 10'h000, 10'h000, 0, 0, 10'h000, 0, 0, 6'd0);
		check("trained not taken", 0, if_prediction);
		// isr flag gives another tag
		cycle(1, 1, 10'h013, 10'h000, 10'h000, 0, 0, 10'h000, 0, 0, 6'd0);
		check("isr tag miss", 10'h000, if_pbt);

		// new jump, stored jump and a mispredicted beq
		test_name = "flush";
		cycle(1, 0, 10'h000, 10'h0a7, 10'h033, 1, 0, 10'h000, 0, 0, 6'd0);
		cycle(1, 0, 10'h000, 10'h000, 10'h000, 0, 0, 10'h000, 0, 0, 6'd0);
		check("jump flush", 1, branch_flush);
		cycle(1, 0, 10'h000, 10'h0a7, 10'h033, 1, 0, 10'h000, 0, 0, 6'd0);
		check("jump in bht", 1, id_jump_in_bht);
		cycle(1, 0, 10'h000, 10'h000, 10'h000, 0, 0, 10'h013, 1, 0, 6'b100000);
		check("mispredict flush", 1, branch_flush);
		repeat (2) cycle(1, 0, 10'h000, 10'h000, 10'h000, 0, 0, 10'h000, 0, 0, 6'd0);
		check("flush ends", 0, branch_flush);

		// inserts and training with en low leave the state alone
		test_name = "enable_low";
		repeat (4) cycle(0, 0, 10'h0c8, 10'h0c8, 10'h111, 1, 0, 10'h013, 1, 0, 6'b100000);
		cycle(1, 0, 10'h0c8, 10'h000, 10'h000, 0, 0, 10'h000, 0, 0, 6'd0);
		check("frozen lookup", 10'h000, if_pbt);

		// all branch kinds under random flags, en and pc pool
		test_name = "random";
		for (int i = 0; i < N_RAND; i++)
			random_cycle();

		// the bound properties sample the last cycle at this edge
		@(posedge CLK);
		#1;
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire
